// ==== build.f ====
rtl/cache_pkg.sv
rtl/cache_tag_store.sv
rtl/cache_data_store.sv
rtl/cache_controller.sv
rtl/cache_top.sv
tb/cache_mem_model.sv
tb/cache_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only -Wall --timing
TOP        = cache_tb
RTL_TOP    = cache_top
FILELIST   = build.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

# the log decides the result, not the exit status of the model
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/cache_tb.sv ====
`timescale 1ns/100ps

module cache_tb;

    localparam int          ASSOC    = 2;
    localparam int          HALF     = 20;
    localparam int          SETTLE   = 10;
    localparam int          TIMEOUT  = 200;
    localparam int          POOL     = 12;
    localparam int          RAND_TAG = 'h3a0;
    localparam logic [31:0] INIT_XOR = 32'h5a5a_c3c3;

    logic                clk;
    logic                arst_n;
    cache_pkg::cpu_req_t cpu_req;
    cache_pkg::cpu_rsp_t cpu_rsp;
    cache_pkg::mem_req_t mem_req;
    cache_pkg::mem_rsp_t mem_rsp;
    logic                retry_start;
    int                  retry_cycles;
    int                  wb_count;
    int                  seed;
    // last value written per address
    logic [31:0]         shadow [logic [31:0]];
    // expected ack responses in request order
    cache_pkg::cpu_rsp_t exp_q [$];

    cache_top #(
        .ASSOCIATIVITY(ASSOC)
    ) i_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    cache_mem_model #(
        .INIT_XOR(INIT_XOR)
    ) i_mem (
        .clk          (clk),
        .arst_n       (arst_n),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .retry_start  (retry_start),
        .retry_cycles (retry_cycles),
        .wb_count     (wb_count)
    );

    always #(HALF) clk = ~clk;

    function automatic logic [31:0] mem_expect(input logic [31:0] adr);
        if (shadow.exists(adr)) begin
            return shadow[adr];
        end
        return adr ^ INIT_XOR;
    endfunction

    function automatic cache_pkg::cache_addr_u make_adr(input int tag, input int index);
        cache_pkg::cache_addr_u a;
        a.raw          = '0;
        a.fields.tag   = tag[cache_pkg::TAG_W-1:0];
        a.fields.index = index[cache_pkg::INDEX_W-1:0];
        return a;
    endfunction

    task automatic stop_on_failure();
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_cpu_rsp(input string name, input cache_pkg::cpu_rsp_t act,
                                 input cache_pkg::cpu_rsp_t exp, input bit with_data);
        if ((with_data && act !== exp) ||
            (!with_data && {act.ack, act.rty} !== {exp.ack, exp.rty})) begin
            $display("error: %s is %h, expected %h", name, act, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_mem_req(input string name, input cache_pkg::mem_req_t act,
                                 input cache_pkg::mem_req_t exp, input bit with_data);
        if ((with_data && act !== exp) ||
            (!with_data && {act.cyc, act.stb, act.we} !== {exp.cyc, exp.stb, exp.we})) begin
            $display("error: %s is %h, expected %h", name, act, exp);
            stop_on_failure();
        end
    endtask

    // present a request and queue the ack it should produce
    task automatic drive_req(input logic we, input cache_pkg::cache_addr_u adr,
                             input logic [31:0] dat);
        cache_pkg::cpu_rsp_t exp;
        @(negedge clk);
        exp.ack = 1'b1;
        exp.rty = 1'b0;
        // the ack cycle shows the word as it was before this access
        exp.dat = mem_expect(adr.raw);
        exp_q.push_back(exp);
        if (we) begin
            shadow[adr.raw] = dat;
        end
        cpu_req.cyc = 1'b1;
        cpu_req.stb = 1'b1;
        cpu_req.we  = we;
        cpu_req.adr = adr;
        cpu_req.dat = dat;
    endtask

    task automatic wait_ack(output int cycles);
        int n;
        n = 0;
        #(SETTLE);
        while (!cpu_rsp.ack) begin
            if (n >= TIMEOUT) begin
                $display("request to %h got no ack within %0d cycles", cpu_req.adr.raw, TIMEOUT);
                stop_on_failure();
            end
            @(negedge clk);
            #(SETTLE);
            n++;
        end
        cycles = n;
    endtask

    task automatic end_req();
        @(negedge clk);
        cpu_req.cyc = 1'b0;
        cpu_req.stb = 1'b0;
        cpu_req.we  = 1'b0;
    endtask

    task automatic cpu_access(input logic we, input cache_pkg::cache_addr_u adr,
                              input logic [31:0] dat, output int cycles);
        drive_req(we, adr, dat);
        wait_ack(cycles);
        end_req();
    endtask

    // every ack is matched against the oldest expected response
    always @(negedge clk) begin
        #(SETTLE);
        if (arst_n && cpu_rsp.ack) begin
            if (exp_q.size() == 0) begin
                $display("the cache acknowledged with no request outstanding");
                stop_on_failure();
            end else begin
                check_cpu_rsp("cpu_rsp", cpu_rsp, exp_q.pop_front(), 1'b1);
            end
        end
    end

    initial begin : main
        cache_pkg::cache_addr_u adr_a;
        cache_pkg::cache_addr_u adr_b;
        cache_pkg::cache_addr_u adr_c;
        cache_pkg::cache_addr_u adr;
        cache_pkg::mem_req_t    exp_mem;
        int                     cycles;
        int                     n;
        int                     r;
        int                     pick;
        int                     wb_before;
        logic [31:0]            wdat;

        clk          = 1'b0;
        arst_n       = 1'b0;
        cpu_req      = '0;
        retry_start  = 1'b0;
        retry_cycles = 0;
        seed         = 50;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // idle outputs after reset
        #(SETTLE);
        check_cpu_rsp("cpu_rsp", cpu_rsp, '{ack: 1'b0, rty: 1'b1, dat: '0}, 1'b0);
        check_mem_req("mem_req", mem_req, '0, 1'b0);

        // read miss, then the same word must hit at once
        adr = make_adr('h20, 1);
        cpu_access(1'b0, adr, '0, cycles);
        cpu_access(1'b0, adr, '0, cycles);
        if (cycles != 0) begin
            $display("read hit at %h was acknowledged %0d cycles late", adr.raw, cycles);
            stop_on_failure();
        end

        // write miss, write hit, each read back
        adr = make_adr('h40, 2);
        cpu_access(1'b1, adr, 32'h1234_5678, cycles);
        cpu_access(1'b0, adr, '0, cycles);
        cpu_access(1'b1, adr, 32'hcafe_f00d, cycles);
        cpu_access(1'b0, adr, '0, cycles);

        // A dirty, B fills the other way, C evicts A
        adr_a = make_adr('h100, 5);
        adr_b = make_adr('h101, 5);
        adr_c = make_adr('h102, 5);
        cpu_access(1'b1, adr_a, 32'hdead_0a0a, cycles);
        cpu_access(1'b0, adr_b, '0, cycles);
        wb_before = wb_count;
        drive_req(1'b0, adr_c, '0);
        n = 0;
        #(SETTLE);
        while (!mem_req.stb) begin
            if (n >= TIMEOUT) begin
                $display("no memory strobe seen for the miss at %h", adr_c.raw);
                stop_on_failure();
            end
            @(negedge clk);
            #(SETTLE);
            n++;
        end
        // first strobe must be the write-back of A
        exp_mem = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr_a, dat: 32'hdead_0a0a};
        check_mem_req("mem_req", mem_req, exp_mem, 1'b1);
        @(negedge clk);
        wait_ack(cycles);
        end_req();
        if (wb_count != wb_before + 1) begin
            $display("error: wb_count is %h, expected %h", wb_count, wb_before + 1);
            stop_on_failure();
        end

        // miss while memory asks for retry
        @(negedge clk);
        retry_start  = 1'b1;
        retry_cycles = 6;
        adr = make_adr('h200, 3);
        drive_req(1'b0, adr, '0);
        retry_start = 1'b0;
        repeat (3) begin
            #(SETTLE);
            check_mem_req("mem_req", mem_req, '{cyc: 1'b1, stb: 1'b0, we: 1'b0,
                          adr: '0, dat: '0}, 1'b0);
            check_cpu_rsp("cpu_rsp", cpu_rsp, '{ack: 1'b0, rty: 1'b1, dat: '0}, 1'b0);
            @(negedge clk);
        end
        wait_ack(cycles);
        end_req();

        // random traffic over a small pool of lines
        for (int i = 0; i < 300; i++) begin
            r    = $random(seed);
            pick = (r & 32'h7fff_ffff) % POOL;
            adr  = make_adr(RAND_TAG + pick / 4, 8 + pick % 4);
            wdat = $random(seed);
            cpu_access(r[5], adr, wdat, cycles);
        end

        #(SETTLE);
        if (exp_q.size() != 0) begin
            $display("%0d requests ended without a checked ack", exp_q.size());
            stop_on_failure();
        end

        $display("** PASS **");
        $finish;
    end

endmodule : cache_tb

// ==== tb/cache_mem_model.sv ====
`timescale 1ns/100ps

module cache_mem_model #(
    parameter logic [31:0] INIT_XOR = 32'h5a5a_c3c3
) (
    input  logic                clk,
    input  logic                arst_n,
    input  cache_pkg::mem_req_t mem_req,
    output cache_pkg::mem_rsp_t mem_rsp,
    input  logic                retry_start,
    input  int                  retry_cycles,
    output int                  wb_count
);

    // words written back so far, everything else reads as its initial pattern
    logic [cache_pkg::DATA_W-1:0] store [logic [cache_pkg::ADDR_W-1:0]];
    logic                         ack_q;
    logic [cache_pkg::DATA_W-1:0] dat_q;
    int                           retry_left;

    function automatic logic [31:0] read_word(input logic [31:0] adr);
        if (store.exists(adr)) begin
            return store[adr];
        end
        return adr ^ INIT_XOR;
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q      <= 1'b0;
            dat_q      <= '0;
            retry_left <= 0;
            wb_count   <= 0;
        end else begin
            if (retry_start) begin
                retry_left <= retry_cycles;
            end else if (retry_left > 0) begin
                retry_left <= retry_left - 1;
            end
            // one ack cycle per strobe
            ack_q <= 1'b0;
            if (mem_req.cyc && mem_req.stb && !ack_q) begin
                ack_q <= 1'b1;
                if (mem_req.we) begin
                    store[mem_req.adr.raw] = mem_req.dat;
                    wb_count <= wb_count + 1;
                end else begin
                    dat_q <= read_word(mem_req.adr.raw);
                end
            end
        end
    end

    assign mem_rsp = '{ack: ack_q, rty: (retry_left != 0), dat: dat_q};

endmodule : cache_mem_model

// ==== rtl/cache_top.sv ====
`timescale 1ns/100ps

module cache_top #(
    parameter int ASSOCIATIVITY = 2
) (
    input  logic                clk,
    input  logic                arst_n,
    input  cache_pkg::cpu_req_t cpu_req,
    output cache_pkg::cpu_rsp_t cpu_rsp,
    output cache_pkg::mem_req_t mem_req,
    input  cache_pkg::mem_rsp_t mem_rsp
);

    localparam int WAY_W = $clog2(ASSOCIATIVITY);

    logic [ASSOCIATIVITY-1:0]     hit;
    logic                         dirty;
    logic [WAY_W-1:0]             victim;
    logic [WAY_W-1:0]             way_sel;
    logic                         fill_sel;
    logic                         tag_sel;
    logic                         load;
    logic                         touch;
    logic                         cpu_ack;
    logic                         cpu_rty;
    logic                         mem_cyc;
    logic                         mem_stb;
    logic                         mem_we;
    logic [cache_pkg::DATA_W-1:0] rd_dat;
    cache_pkg::cache_addr_u       mem_adr;

    cache_tag_store #(
        .ASSOCIATIVITY(ASSOCIATIVITY)
    ) i_tag_store (
        .clk     (clk),
        .arst_n  (arst_n),
        .cpu_adr (cpu_req.adr),
        .cpu_we  (cpu_req.we),
        .way_sel (way_sel),
        .tag_sel (tag_sel),
        .load    (load),
        .touch   (touch),
        .hit     (hit),
        .dirty   (dirty),
        .victim  (victim),
        .mem_adr (mem_adr)
    );

    cache_data_store #(
        .ASSOCIATIVITY(ASSOCIATIVITY)
    ) i_data_store (
        .clk      (clk),
        .index    (cpu_req.adr.fields.index),
        .way_sel  (way_sel),
        .fill_sel (fill_sel),
        .load     (load),
        .cpu_dat  (cpu_req.dat),
        .mem_dat  (mem_rsp.dat),
        .rd_dat   (rd_dat)
    );

    cache_controller #(
        .ASSOCIATIVITY(ASSOCIATIVITY)
    ) i_controller (
        .clk      (clk),
        .arst_n   (arst_n),
        .cpu_cyc  (cpu_req.cyc),
        .cpu_stb  (cpu_req.stb),
        .cpu_we   (cpu_req.we),
        .hit      (hit),
        .dirty    (dirty),
        .victim   (victim),
        .mem_ack  (mem_rsp.ack),
        .mem_rty  (mem_rsp.rty),
        .way_sel  (way_sel),
        .fill_sel (fill_sel),
        .tag_sel  (tag_sel),
        .load     (load),
        .touch    (touch),
        .cpu_ack  (cpu_ack),
        .cpu_rty  (cpu_rty),
        .mem_cyc  (mem_cyc),
        .mem_stb  (mem_stb),
        .mem_we   (mem_we)
    );

    // read word serves the cpu on a hit and memory on a write-back
    assign cpu_rsp = '{ack: cpu_ack, rty: cpu_rty, dat: rd_dat};
    assign mem_req = '{cyc: mem_cyc, stb: mem_stb, we: mem_we, adr: mem_adr, dat: rd_dat};

endmodule : cache_top

// ==== rtl/cache_controller.sv ====
`timescale 1ns/100ps

module cache_controller #(
    parameter int ASSOCIATIVITY = 2
) (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             cpu_cyc,
    input  logic                             cpu_stb,
    input  logic                             cpu_we,
    input  logic [ASSOCIATIVITY-1:0]         hit,
    input  logic                             dirty,
    input  logic [$clog2(ASSOCIATIVITY)-1:0] victim,
    input  logic                             mem_ack,
    input  logic                             mem_rty,
    output logic [$clog2(ASSOCIATIVITY)-1:0] way_sel,
    output logic                             fill_sel,
    output logic                             tag_sel,
    output logic                             load,
    output logic                             touch,
    output logic                             cpu_ack,
    output logic                             cpu_rty,
    output logic                             mem_cyc,
    output logic                             mem_stb,
    output logic                             mem_we
);

    localparam int WAY_W = $clog2(ASSOCIATIVITY);

    enum logic [2:0] {
        S_IDLE,
        S_FLUSH,
        S_FLUSH_WAIT,
        S_FETCH,
        S_FETCH_WAIT
    } state, next_state;

    logic cpu_req;

    assign cpu_req = cpu_cyc && cpu_stb;

    always_comb begin : state_outputs
        way_sel  = '0;
        fill_sel = 1'b0;
        tag_sel  = 1'b0;
        load     = 1'b0;
        touch    = 1'b0;
        cpu_ack  = 1'b0;
        cpu_rty  = 1'b1;
        mem_cyc  = 1'b0;
        mem_stb  = 1'b0;
        mem_we   = 1'b0;

        case (state)
            S_IDLE: begin
                if (cpu_req && (|hit)) begin
                    // encode the hit vector
                    for (int i = 0; i < ASSOCIATIVITY; i++) begin
                        if (hit[i]) begin
                            way_sel = i[WAY_W-1:0];
                        end
                    end
                    touch   = 1'b1;
                    load    = cpu_we;
                    cpu_ack = 1'b1;
                    cpu_rty = 1'b0;
                end else if (cpu_req) begin
                    // claim the memory bus, strobe comes later
                    way_sel = victim;
                    mem_cyc = 1'b1;
                end
            end

            S_FLUSH: begin
                // victim tag and data go out
                way_sel = victim;
                mem_cyc = 1'b1;
                mem_stb = 1'b1;
                mem_we  = 1'b1;
            end

            S_FLUSH_WAIT: begin
                way_sel = victim;
                mem_cyc = 1'b1;
                mem_we  = 1'b1;
            end

            S_FETCH: begin
                way_sel  = victim;
                tag_sel  = 1'b1;
                fill_sel = 1'b1;
                // capture the word in the ack cycle
                load     = mem_ack;
                mem_cyc  = 1'b1;
                mem_stb  = 1'b1;
            end

            S_FETCH_WAIT: begin
                way_sel = victim;
                tag_sel = 1'b1;
                mem_cyc = 1'b1;
            end

            default: begin
                mem_cyc = 1'b0;
            end
        endcase
    end

    always_comb begin : state_next
        next_state = state;
        case (state)
            S_IDLE: begin
                // miss waits here until memory stops asking for a retry
                if (cpu_req && !(|hit) && !mem_rty) begin
                    if (dirty) begin
                        next_state = S_FLUSH;
                    end else begin
                        next_state = S_FETCH;
                    end
                end
            end
            S_FLUSH:      if (mem_ack)  next_state = S_FLUSH_WAIT;
            S_FLUSH_WAIT: if (!mem_ack) next_state = S_FETCH;
            S_FETCH:      if (mem_ack)  next_state = S_FETCH_WAIT;
            S_FETCH_WAIT: if (!mem_ack) next_state = S_IDLE;
            default:      next_state = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // the cpu is only acked while the memory bus is idle
    a_ack_no_cyc : assert property (@(posedge clk) disable iff (!arst_n)
        !(cpu_ack && mem_cyc));

    a_stb_in_cyc : assert property (@(posedge clk) disable iff (!arst_n)
        mem_stb |-> mem_cyc);

    // a wait state ends only once ack has fallen
    a_wait_exit : assert property (@(posedge clk) disable iff (!arst_n)
        (state inside {S_FLUSH_WAIT, S_FETCH_WAIT})
        |=> (state == $past(state)) || !$past(mem_ack));

endmodule : cache_controller

// ==== rtl/cache_data_store.sv ====
`timescale 1ns/100ps

module cache_data_store #(
    parameter int ASSOCIATIVITY = 2
) (
    input  logic                             clk,
    input  logic [cache_pkg::INDEX_W-1:0]    index,
    input  logic [$clog2(ASSOCIATIVITY)-1:0] way_sel,
    input  logic                             fill_sel,
    input  logic                             load,
    input  logic [cache_pkg::DATA_W-1:0]     cpu_dat,
    input  logic [cache_pkg::DATA_W-1:0]     mem_dat,
    output logic [cache_pkg::DATA_W-1:0]     rd_dat
);

    localparam int SETS = 1 << cache_pkg::INDEX_W;

    // one word per line
    logic [cache_pkg::DATA_W-1:0] line_q [SETS][ASSOCIATIVITY];
    logic [cache_pkg::DATA_W-1:0] wr_dat;

    // memory data on a fill, cpu data on a write hit
    always_comb begin
        if (fill_sel) begin
            wr_dat = mem_dat;
        end else begin
            wr_dat = cpu_dat;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            line_q[index][way_sel] <= wr_dat;
        end
    end

    // same port feeds hit reads and write-back data
    assign rd_dat = line_q[index][way_sel];

endmodule : cache_data_store

// ==== rtl/cache_tag_store.sv ====
`timescale 1ns/100ps

module cache_tag_store #(
    parameter int ASSOCIATIVITY = 2
) (
    input  logic                             clk,
    input  logic                             arst_n,
    input  cache_pkg::cache_addr_u           cpu_adr,
    input  logic                             cpu_we,
    input  logic [$clog2(ASSOCIATIVITY)-1:0] way_sel,
    input  logic                             tag_sel,
    input  logic                             load,
    input  logic                             touch,
    output logic [ASSOCIATIVITY-1:0]         hit,
    output logic                             dirty,
    output logic [$clog2(ASSOCIATIVITY)-1:0] victim,
    output cache_pkg::cache_addr_u           mem_adr
);

    localparam int WAY_W = $clog2(ASSOCIATIVITY);
    localparam int SETS  = 1 << cache_pkg::INDEX_W;

    logic [cache_pkg::INDEX_W-1:0] idx;
    logic [cache_pkg::TAG_W-1:0]   tag_q   [SETS][ASSOCIATIVITY];
    logic [ASSOCIATIVITY-1:0]      valid_q [SETS];
    logic [ASSOCIATIVITY-1:0]      dirty_q [SETS];
    // tree bits, heap order, 0 points the victim at the lower half
    logic [ASSOCIATIVITY-2:0]      plru_q  [SETS];
    logic [ASSOCIATIVITY-2:0]      plru_cur;
    logic [ASSOCIATIVITY-2:0]      plru_nxt;

    assign idx      = cpu_adr.fields.index;
    assign plru_cur = plru_q[idx];

    // compare every way of the set in parallel
    always_comb begin
        for (int w = 0; w < ASSOCIATIVITY; w++) begin
            hit[w] = valid_q[idx][w] && (tag_q[idx][w] == cpu_adr.fields.tag);
        end
    end

    // follow the tree from the root down to a leaf
    always_comb begin : victim_walk
        int node;
        node   = 0;
        victim = '0;
        for (int lvl = 0; lvl < WAY_W; lvl++) begin
            victim[WAY_W-1-lvl] = plru_cur[node];
            node = 2 * node + 1 + int'(plru_cur[node]);
        end
    end

    // every node on the path of way_sel points away from it
    always_comb begin : touch_walk
        int node;
        node     = 0;
        plru_nxt = plru_cur;
        for (int lvl = 0; lvl < WAY_W; lvl++) begin
            plru_nxt[node] = ~way_sel[WAY_W-1-lvl];
            node = 2 * node + 1 + int'(way_sel[WAY_W-1-lvl]);
        end
    end

    assign dirty = dirty_q[idx][victim];

    // write-back goes to the victim line, fetch to the cpu address
    always_comb begin
        mem_adr = cpu_adr;
        if (!tag_sel) begin
            mem_adr.fields.tag    = tag_q[idx][victim];
            mem_adr.fields.offset = '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                plru_q[s]  <= '0;
            end
        end else begin
            if (load) begin
                valid_q[idx][way_sel] <= 1'b1;
                // a fill brings a clean line, a cpu write dirties it
                if (tag_sel) begin
                    dirty_q[idx][way_sel] <= 1'b0;
                end else if (cpu_we) begin
                    dirty_q[idx][way_sel] <= 1'b1;
                end
            end
            if (touch) begin
                plru_q[idx] <= plru_nxt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            tag_q[idx][way_sel] <= cpu_adr.fields.tag;
        end
    end

    // a tag lives in at most one way of a set
    a_hit_onehot : assert property (@(posedge clk) disable iff (!arst_n) $onehot0(hit));

endmodule : cache_tag_store

// ==== rtl/cache_pkg.sv ====
package cache_pkg;

    // address and data widths
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int OFFSET_W = 2;
    localparam int INDEX_W  = 4;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    // address split as seen by the tag and data stores
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } cache_addr_t;

    // one address word, flat for the buses or split for the stores
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        cache_addr_t       fields;
    } cache_addr_u;

    // cpu side, master to cache
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        cache_addr_u       adr;
        logic [DATA_W-1:0] dat;
    } cpu_req_t;

    // cpu side, cache back to master
    typedef struct packed {
        logic              ack;
        logic              rty;
        logic [DATA_W-1:0] dat;
    } cpu_rsp_t;

    // memory side, cache to memory slave
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        cache_addr_u       adr;
        logic [DATA_W-1:0] dat;
    } mem_req_t;

    // memory side, slave back to cache
    typedef struct packed {
        logic              ack;
        logic              rty;
        logic [DATA_W-1:0] dat;
    } mem_rsp_t;

endpackage : cache_pkg
